// File: common/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// lane counts of one issue group
`define ALU_NUM 2
`define MEM_NUM 1   // the memory lane logic assumes exactly one

// every ALU lane and the memory lane can be named as a forward source
`define FWD_NUM (`ALU_NUM + `MEM_NUM)

// commit beats the ROB accepts before it has to return a credit
`define COMMIT_CREDITS 4

`define ROB_AW 5

`endif

// File: common/exec_pkg.sv
`include "exec_settings.svh"
`default_nettype none

package exec_pkg;

    typedef logic [31:0]        word_t;
    typedef logic [31:0]        vaddr_t;
    typedef logic [`ROB_AW-1:0] rob_addr_t;
    typedef logic [2:0]         alu_func_t;
    typedef logic [1:0]         fwd_sel_t;  // 0..ALU_NUM-1 are ALU lanes, ALU_NUM is memory
    typedef logic [2:0]         credit_t;   // wide enough to hold COMMIT_CREDITS

    // ALU function codes
    localparam alu_func_t ALU_ADD = 3'd0;
    localparam alu_func_t ALU_SUB = 3'd1;
    localparam alu_func_t ALU_AND = 3'd2;
    localparam alu_func_t ALU_OR  = 3'd3;
    localparam alu_func_t ALU_XOR = 3'd4;
    localparam alu_func_t ALU_SLT = 3'd5;  // signed compare
    localparam alu_func_t ALU_SLL = 3'd6;
    localparam alu_func_t ALU_SRL = 3'd7;

endpackage

`default_nettype wire

// File: execute/operand_forward.sv
`timescale 1ns/1ps
`include "exec_settings.svh"
`default_nettype none

module operand_forward (
    input  exec_pkg::word_t                  issued,
    input  logic                             fw_valid,
    input  exec_pkg::fwd_sel_t               fw_sel,
    input  exec_pkg::word_t [`FWD_NUM-1:0]   fwd_data,
    output exec_pkg::word_t                  operand
);
    logic sel_in_range;

    // a select past the last source never forwards
    assign sel_in_range = fw_sel < `FWD_NUM;

    always_comb begin
        operand = issued;
        if (fw_valid && sel_in_range) begin
            operand = fwd_data[fw_sel];  // result of the last commit beat
        end
    end

endmodule

`default_nettype wire

// File: execute/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  exec_pkg::word_t     a,
    input  exec_pkg::word_t     b,
    input  exec_pkg::alu_func_t func,
    output exec_pkg::word_t     c,
    output logic                overflow
);
    exec_pkg::word_t sum;
    exec_pkg::word_t diff;
    logic            add_of;
    logic            sub_of;

    assign sum  = a + b;
    assign diff = a - b;

    // operands of equal sign whose sum flips sign
    assign add_of = (a[31] == b[31]) && (sum[31] != a[31]);
    // operands of opposite sign whose difference takes the sign of b
    assign sub_of = (a[31] != b[31]) && (diff[31] != a[31]);

    always_comb begin
        c        = sum;
        overflow = 1'b0;
        case (func)
            exec_pkg::ALU_ADD: begin
                c        = sum;
                overflow = add_of;
            end
            exec_pkg::ALU_SUB: begin
                c        = diff;
                overflow = sub_of;
            end
            exec_pkg::ALU_AND: c = a & b;
            exec_pkg::ALU_OR:  c = a | b;
            exec_pkg::ALU_XOR: c = a ^ b;
            exec_pkg::ALU_SLT: c = {31'b0, $signed(a) < $signed(b)};
            exec_pkg::ALU_SLL: c = a << b[4:0];
            exec_pkg::ALU_SRL: c = a >> b[4:0];
            default:           c = sum;
        endcase
    end

endmodule

`default_nettype wire

// File: execute/agu.sv
`timescale 1ns/1ps
`default_nettype none

module agu (
    input  exec_pkg::word_t  base,
    input  exec_pkg::word_t  offset,
    input  exec_pkg::word_t  wdata,
    input  exec_pkg::word_t  rd,
    input  logic             is_load,
    input  logic             valid,
    output exec_pkg::vaddr_t addr,
    output exec_pkg::word_t  data,
    output logic             read_req,
    output logic             write_req,
    output logic             exc_load,
    output logic             exc_save
);
    logic misaligned;

    assign addr       = base + offset;
    assign misaligned = addr[1:0] != 2'b00;  // word accesses only

    assign exc_load = valid & is_load & misaligned;
    assign exc_save = valid & ~is_load & misaligned;

    // a faulting access never reaches memory
    assign read_req  = valid & is_load & ~misaligned;
    assign write_req = valid & ~is_load & ~misaligned;

    assign data = is_load ? rd : wdata;

endmodule

`default_nettype wire

// File: execute/execute.sv
`timescale 1ns/1ps
`include "exec_settings.svh"
`default_nettype none

module execute (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 held_valid,
    input  logic [`ALU_NUM-1:0]                  held_alu_valid,
    input  exec_pkg::alu_func_t [`ALU_NUM-1:0]   held_alu_func,
    input  exec_pkg::word_t [`ALU_NUM-1:0]       held_alu_src1,
    input  exec_pkg::word_t [`ALU_NUM-1:0]       held_alu_src2,
    input  exec_pkg::rob_addr_t [`ALU_NUM-1:0]   held_alu_dst,
    input  logic [`ALU_NUM-1:0]                  held_alu_fw1_valid,
    input  exec_pkg::fwd_sel_t [`ALU_NUM-1:0]    held_alu_fw1_sel,
    input  logic [`ALU_NUM-1:0]                  held_alu_fw2_valid,
    input  exec_pkg::fwd_sel_t [`ALU_NUM-1:0]    held_alu_fw2_sel,
    input  logic                                 held_mem_valid,
    input  logic                                 held_mem_is_load,
    input  exec_pkg::word_t                      held_mem_base,
    input  exec_pkg::word_t                      held_mem_offset,
    input  exec_pkg::word_t                      held_mem_wdata,
    input  exec_pkg::rob_addr_t                  held_mem_dst,
    input  logic                                 held_mem_fw_valid,
    input  exec_pkg::fwd_sel_t                   held_mem_fw_sel,
    input  logic                                 d_data_ok,
    input  exec_pkg::word_t                      rd,
    input  logic                                 commit_credit,
    output logic                                 advance,
    output logic                                 mread_valid,
    output exec_pkg::vaddr_t                     mread_addr,
    output logic                                 mwrite_valid,
    output exec_pkg::vaddr_t                     mwrite_addr,
    output exec_pkg::word_t                      mwrite_data,
    output logic                                 commit_valid,
    output logic [`ALU_NUM-1:0]                  alu_commit_valid,
    output exec_pkg::word_t [`ALU_NUM-1:0]       alu_commit_data,
    output exec_pkg::rob_addr_t [`ALU_NUM-1:0]   alu_commit_rob,
    output logic [`ALU_NUM-1:0]                  alu_commit_of,
    output logic                                 agu_commit_valid,
    output exec_pkg::word_t                      agu_commit_data,
    output exec_pkg::vaddr_t                     agu_commit_addr,
    output exec_pkg::rob_addr_t                  agu_commit_rob,
    output logic                                 agu_commit_exc_load,
    output logic                                 agu_commit_exc_save
);
    exec_pkg::word_t [`FWD_NUM-1:0] fwd_data;
    exec_pkg::word_t [`ALU_NUM-1:0] alu_a;
    exec_pkg::word_t [`ALU_NUM-1:0] alu_b;
    exec_pkg::word_t [`ALU_NUM-1:0] alu_c;
    logic [`ALU_NUM-1:0]            alu_of;
    exec_pkg::word_t                agu_base;
    exec_pkg::vaddr_t               agu_addr;
    exec_pkg::word_t                agu_data;
    logic                           read_req;
    logic                           write_req;
    logic                           exc_load;
    logic                           exc_save;
    exec_pkg::credit_t              credits;

    // the commit register doubles as the forward source
    assign fwd_data = {agu_commit_data, alu_commit_data};

    for (genvar i = 0; i < `ALU_NUM; i++) begin : g_alu
        operand_forward fwd1_i (.issued(held_alu_src1[i]), .fw_valid(held_alu_fw1_valid[i]),
                                .fw_sel(held_alu_fw1_sel[i]), .fwd_data(fwd_data),
                                .operand(alu_a[i]));
        operand_forward fwd2_i (.issued(held_alu_src2[i]), .fw_valid(held_alu_fw2_valid[i]),
                                .fw_sel(held_alu_fw2_sel[i]), .fwd_data(fwd_data),
                                .operand(alu_b[i]));
        alu alu_i (.a(alu_a[i]), .b(alu_b[i]), .func(held_alu_func[i]),
                   .c(alu_c[i]), .overflow(alu_of[i]));
    end

    operand_forward fwd_base_i (.issued(held_mem_base), .fw_valid(held_mem_fw_valid),
                                .fw_sel(held_mem_fw_sel), .fwd_data(fwd_data),
                                .operand(agu_base));

    agu agu_i (
        .base(agu_base), .offset(held_mem_offset), .wdata(held_mem_wdata), .rd(rd),
        .is_load(held_mem_is_load), .valid(held_valid & held_mem_valid),
        .addr(agu_addr), .data(agu_data), .read_req(read_req), .write_req(write_req),
        .exc_load(exc_load), .exc_save(exc_save)
    );

    // a pending load holds the group until memory answers
    assign advance = held_valid && (credits != '0) && !(read_req && !d_data_ok);

    assign mread_valid  = read_req;
    assign mread_addr   = agu_addr;
    assign mwrite_valid = write_req & advance;  // stores fire once, in the advance cycle
    assign mwrite_addr  = agu_addr;
    assign mwrite_data  = held_mem_wdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= exec_pkg::credit_t'(`COMMIT_CREDITS);
        end else begin
            credits <= credits - exec_pkg::credit_t'(advance)
                               + exec_pkg::credit_t'(commit_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit_valid     <= 1'b0;
            alu_commit_valid <= '0;
            agu_commit_valid <= 1'b0;
        end else begin
            commit_valid <= advance;
            if (advance) begin
                alu_commit_valid <= held_alu_valid;
                agu_commit_valid <= held_mem_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            alu_commit_data     <= alu_c;
            alu_commit_rob      <= held_alu_dst;
            alu_commit_of       <= alu_of & held_alu_valid;
            agu_commit_data     <= agu_data;
            agu_commit_addr     <= agu_addr;
            agu_commit_rob      <= held_mem_dst;
            agu_commit_exc_load <= exc_load;
            agu_commit_exc_save <= exc_save;
        end
    end

endmodule

`default_nettype wire

// File: design/issue_reg.sv
`timescale 1ns/1ps
`include "exec_settings.svh"
`default_nettype none

module issue_reg (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 advance,
    input  logic                                 issue_valid,
    input  logic [`ALU_NUM-1:0]                  alu_valid,
    input  exec_pkg::alu_func_t [`ALU_NUM-1:0]   alu_func,
    input  exec_pkg::word_t [`ALU_NUM-1:0]       alu_src1,
    input  exec_pkg::word_t [`ALU_NUM-1:0]       alu_src2,
    input  exec_pkg::rob_addr_t [`ALU_NUM-1:0]   alu_dst,
    input  logic [`ALU_NUM-1:0]                  alu_fw1_valid,
    input  exec_pkg::fwd_sel_t [`ALU_NUM-1:0]    alu_fw1_sel,
    input  logic [`ALU_NUM-1:0]                  alu_fw2_valid,
    input  exec_pkg::fwd_sel_t [`ALU_NUM-1:0]    alu_fw2_sel,
    input  logic                                 mem_valid,
    input  logic                                 mem_is_load,
    input  exec_pkg::word_t                      mem_base,
    input  exec_pkg::word_t                      mem_offset,
    input  exec_pkg::word_t                      mem_wdata,
    input  exec_pkg::rob_addr_t                  mem_dst,
    input  logic                                 mem_fw_valid,
    input  exec_pkg::fwd_sel_t                   mem_fw_sel,
    output logic                                 issue_credit,
    output logic                                 held_valid,
    output logic [`ALU_NUM-1:0]                  held_alu_valid,
    output exec_pkg::alu_func_t [`ALU_NUM-1:0]   held_alu_func,
    output exec_pkg::word_t [`ALU_NUM-1:0]       held_alu_src1,
    output exec_pkg::word_t [`ALU_NUM-1:0]       held_alu_src2,
    output exec_pkg::rob_addr_t [`ALU_NUM-1:0]   held_alu_dst,
    output logic [`ALU_NUM-1:0]                  held_alu_fw1_valid,
    output exec_pkg::fwd_sel_t [`ALU_NUM-1:0]    held_alu_fw1_sel,
    output logic [`ALU_NUM-1:0]                  held_alu_fw2_valid,
    output exec_pkg::fwd_sel_t [`ALU_NUM-1:0]    held_alu_fw2_sel,
    output logic                                 held_mem_valid,
    output logic                                 held_mem_is_load,
    output exec_pkg::word_t                      held_mem_base,
    output exec_pkg::word_t                      held_mem_offset,
    output exec_pkg::word_t                      held_mem_wdata,
    output exec_pkg::rob_addr_t                  held_mem_dst,
    output logic                                 held_mem_fw_valid,
    output exec_pkg::fwd_sel_t                   held_mem_fw_sel
);
    // the issuer may refill in the same cycle the held group leaves
    assign issue_credit = held_valid & advance;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
        end else if (issue_valid) begin
            held_valid <= 1'b1;
        end else if (advance) begin
            held_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            held_alu_valid     <= alu_valid;
            held_alu_func      <= alu_func;
            held_alu_src1      <= alu_src1;
            held_alu_src2      <= alu_src2;
            held_alu_dst       <= alu_dst;
            held_alu_fw1_valid <= alu_fw1_valid;
            held_alu_fw1_sel   <= alu_fw1_sel;
            held_alu_fw2_valid <= alu_fw2_valid;
            held_alu_fw2_sel   <= alu_fw2_sel;
            held_mem_valid     <= mem_valid;
            held_mem_is_load   <= mem_is_load;
            held_mem_base      <= mem_base;
            held_mem_offset    <= mem_offset;
            held_mem_wdata     <= mem_wdata;
            held_mem_dst       <= mem_dst;
            held_mem_fw_valid  <= mem_fw_valid;
            held_mem_fw_sel    <= mem_fw_sel;
        end
    end

endmodule

`default_nettype wire

// File: design/execute_top.sv
`timescale 1ns/1ps
`include "exec_settings.svh"
`default_nettype none

module execute_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 issue_valid,
    input  logic [`ALU_NUM-1:0]                  alu_valid,
    input  exec_pkg::alu_func_t [`ALU_NUM-1:0]   alu_func,
    input  exec_pkg::word_t [`ALU_NUM-1:0]       alu_src1,
    input  exec_pkg::word_t [`ALU_NUM-1:0]       alu_src2,
    input  exec_pkg::rob_addr_t [`ALU_NUM-1:0]   alu_dst,
    input  logic [`ALU_NUM-1:0]                  alu_fw1_valid,
    input  exec_pkg::fwd_sel_t [`ALU_NUM-1:0]    alu_fw1_sel,
    input  logic [`ALU_NUM-1:0]                  alu_fw2_valid,
    input  exec_pkg::fwd_sel_t [`ALU_NUM-1:0]    alu_fw2_sel,
    input  logic                                 mem_valid,
    input  logic                                 mem_is_load,
    input  exec_pkg::word_t                      mem_base,
    input  exec_pkg::word_t                      mem_offset,
    input  exec_pkg::word_t                      mem_wdata,
    input  exec_pkg::rob_addr_t                  mem_dst,
    input  logic                                 mem_fw_valid,
    input  exec_pkg::fwd_sel_t                   mem_fw_sel,
    output logic                                 issue_credit,
    output logic                                 mread_valid,
    output exec_pkg::vaddr_t                     mread_addr,
    output logic                                 mwrite_valid,
    output exec_pkg::vaddr_t                     mwrite_addr,
    output exec_pkg::word_t                      mwrite_data,
    input  logic                                 d_data_ok,
    input  exec_pkg::word_t                      rd,
    output logic                                 commit_valid,
    output logic [`ALU_NUM-1:0]                  alu_commit_valid,
    output exec_pkg::word_t [`ALU_NUM-1:0]       alu_commit_data,
    output exec_pkg::rob_addr_t [`ALU_NUM-1:0]   alu_commit_rob,
    output logic [`ALU_NUM-1:0]                  alu_commit_of,
    output logic                                 agu_commit_valid,
    output exec_pkg::word_t                      agu_commit_data,
    output exec_pkg::vaddr_t                     agu_commit_addr,
    output exec_pkg::rob_addr_t                  agu_commit_rob,
    output logic                                 agu_commit_exc_load,
    output logic                                 agu_commit_exc_save,
    input  logic                                 commit_credit
);
    logic                               advance;
    logic                               held_valid;
    logic [`ALU_NUM-1:0]                held_alu_valid;
    exec_pkg::alu_func_t [`ALU_NUM-1:0] held_alu_func;
    exec_pkg::word_t [`ALU_NUM-1:0]     held_alu_src1;
    exec_pkg::word_t [`ALU_NUM-1:0]     held_alu_src2;
    exec_pkg::rob_addr_t [`ALU_NUM-1:0] held_alu_dst;
    logic [`ALU_NUM-1:0]                held_alu_fw1_valid;
    exec_pkg::fwd_sel_t [`ALU_NUM-1:0]  held_alu_fw1_sel;
    logic [`ALU_NUM-1:0]                held_alu_fw2_valid;
    exec_pkg::fwd_sel_t [`ALU_NUM-1:0]  held_alu_fw2_sel;
    logic                               held_mem_valid;
    logic                               held_mem_is_load;
    exec_pkg::word_t                    held_mem_base;
    exec_pkg::word_t                    held_mem_offset;
    exec_pkg::word_t                    held_mem_wdata;
    exec_pkg::rob_addr_t                held_mem_dst;
    logic                               held_mem_fw_valid;
    exec_pkg::fwd_sel_t                 held_mem_fw_sel;

    issue_reg issue_reg_i (.*);  // the ereg

    execute execute_i (.*);

endmodule

`default_nettype wire

// File: tests/execute_top_assert.sv
`timescale 1ns/1ps
`include "exec_settings.svh"
`default_nettype none

module execute_top_assert (
    input logic                clk,
    input logic                rst_n,
    input logic                advance,
    input exec_pkg::credit_t   credits,
    input logic                mread_valid,
    input exec_pkg::vaddr_t    mread_addr,
    input logic                d_data_ok,
    input logic                mwrite_valid,
    input logic                commit_valid,
    input logic                commit_credit,
    input logic [`ALU_NUM-1:0] alu_commit_valid,
    input logic                agu_commit_valid
);
    exec_pkg::credit_t in_rob;  // beats delivered and not yet freed by the ROB

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_rob <= '0;
        end else begin
            in_rob <= in_rob + exec_pkg::credit_t'(commit_valid)
                             - exec_pkg::credit_t'(commit_credit);
        end
    end

    // the ROB only has room for COMMIT_CREDITS beats
    beat_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> in_rob < exec_pkg::credit_t'(`COMMIT_CREDITS))
        else $error("commit beat sent while the ROB had no free credit");

    // the read request waits for memory without changing
    mread_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mread_valid && !d_data_ok |=> mread_valid && $stable(mread_addr))
        else $error("memory read request changed before d_data_ok");

    valids_low_after_reset: assert property (@(posedge clk)
        !rst_n |=> !commit_valid && !mread_valid && !mwrite_valid
                   && alu_commit_valid == '0 && !agu_commit_valid)
        else $error("valid output high right after reset");

    credits_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= exec_pkg::credit_t'(`COMMIT_CREDITS))
        else $error("commit credit count above its reset value");

endmodule

bind execute execute_top_assert execute_top_assert_i (.*);

`default_nettype wire

// File: tests/execute_top_tb.sv
`timescale 1ns/1ps
`include "exec_settings.svh"
`default_nettype none

module execute_top_tb;
    localparam int N = `ALU_NUM;
    localparam int TOTAL_GROUPS = 146;

    logic clk, rst_n, issue_valid, mem_valid, mem_is_load, mem_fw_valid;
    logic [N-1:0] alu_valid, alu_fw1_valid, alu_fw2_valid, alu_commit_valid, alu_commit_of;
    exec_pkg::alu_func_t [N-1:0] alu_func;
    exec_pkg::word_t [N-1:0] alu_src1, alu_src2, alu_commit_data;
    exec_pkg::rob_addr_t [N-1:0] alu_dst, alu_commit_rob;
    exec_pkg::fwd_sel_t [N-1:0] alu_fw1_sel, alu_fw2_sel;
    exec_pkg::fwd_sel_t mem_fw_sel;
    exec_pkg::word_t mem_base, mem_offset, mem_wdata, rd, mwrite_data, agu_commit_data;
    exec_pkg::vaddr_t mread_addr, mwrite_addr, agu_commit_addr;
    exec_pkg::rob_addr_t mem_dst, agu_commit_rob;
    logic issue_credit, mread_valid, mwrite_valid, d_data_ok, commit_valid, commit_credit;
    logic agu_commit_valid, agu_commit_exc_load, agu_commit_exc_save;

    integer seed = 32'h1210_fa17;
    string test_name = "reset";
    logic have_credit, withhold, have_prev;
    int sent, credits_back, beats, owed, delay;
    exec_pkg::word_t [N-1:0] prev_alu;
    exec_pkg::word_t prev_mem;
    exec_pkg::word_t [N-1:0] q_alu[$];
    logic [N-1:0] q_of[$];
    exec_pkg::word_t q_mem[$], q_addr[$], q_rd_addr[$], q_wr_addr[$], q_wr_data[$];
    logic [1:0] q_exc[$];
    logic [`ROB_AW*(N+1)-1:0] q_rob[$];

    execute_top execute_top_i (.*);

    always #20 clk = ~clk;

    task automatic die(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check(string what, logic [63:0] exp, logic [63:0] act);
        assert (exp === act) else
            die($sformatf("Fail %s %s: expected %0h, actual %0h", test_name, what, exp, act));
    endtask

    function automatic bit coin();
        return ($random(seed) % 2) != 0;
    endfunction

    function automatic exec_pkg::word_t mem_word(exec_pkg::vaddr_t a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b1);  // every address bit matters
    endfunction

    function automatic exec_pkg::word_t pick_operand(bit corner);
        if (!corner) return $random(seed);
        case ($unsigned($random(seed)) % 5)
            0: return 32'h0000_0000;
            1: return 32'h0000_0001;
            2: return 32'h7fff_ffff;
            3: return 32'h8000_0000;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic exec_pkg::word_t fwd_value(exec_pkg::fwd_sel_t sel);
        return (sel == N) ? prev_mem : prev_alu[sel];
    endfunction

    // bit 32 is the signed overflow flag
    function automatic logic [32:0] ref_alu(exec_pkg::word_t a, exec_pkg::word_t b,
                                            exec_pkg::alu_func_t f);
        logic [32:0] ext;
        ext = 33'd0;
        case (f)
            exec_pkg::ALU_ADD: ext = {a[31], a} + {b[31], b};
            exec_pkg::ALU_SUB: ext = {a[31], a} - {b[31], b};
            exec_pkg::ALU_AND: ext = {1'b0, a & b};
            exec_pkg::ALU_OR:  ext = {1'b0, a | b};
            exec_pkg::ALU_XOR: ext = {1'b0, a ^ b};
            exec_pkg::ALU_SLT: ext = ($signed(a) < $signed(b)) ? 33'd1 : 33'd0;
            exec_pkg::ALU_SLL: ext = {1'b0, a << b[4:0]};
            default:           ext = {1'b0, a >> b[4:0]};
        endcase
        if (f == exec_pkg::ALU_ADD || f == exec_pkg::ALU_SUB) begin
            return {ext[32] != ext[31], ext[31:0]};
        end
        return {1'b0, ext[31:0]};
    endfunction

    // mem_kind 0 is an aligned load, 1 an aligned store, 2 a misaligned access
    task automatic send_group(bit corner, bit use_fwd, int mem_kind);
        exec_pkg::word_t [N-1:0] res;
        logic [N-1:0] of;
        logic [32:0] r;
        exec_pkg::word_t a, b, base, mdata;
        exec_pkg::vaddr_t addr;
        logic misal;
        @(negedge clk);
        while (!have_credit) @(negedge clk);
        have_credit = 1'b0;
        issue_valid = 1'b1;
        for (int i = 0; i < N; i++) begin
            alu_func[i] = $random(seed);
            alu_src1[i] = pick_operand(corner);
            alu_src2[i] = pick_operand(corner);
            alu_dst[i] = $random(seed);
            alu_fw1_valid[i] = use_fwd && have_prev && coin();
            alu_fw2_valid[i] = use_fwd && have_prev && coin();
            alu_fw1_sel[i] = $unsigned($random(seed)) % 3;
            alu_fw2_sel[i] = $unsigned($random(seed)) % 3;
            a = alu_fw1_valid[i] ? fwd_value(alu_fw1_sel[i]) : alu_src1[i];
            b = alu_fw2_valid[i] ? fwd_value(alu_fw2_sel[i]) : alu_src2[i];
            r = ref_alu(a, b, alu_func[i]);
            res[i] = r[31:0];
            of[i] = r[32];
        end
        mem_is_load = (mem_kind == 0) || (mem_kind == 2 && coin());
        mem_fw_valid = use_fwd && have_prev && mem_kind == 2 && coin();
        mem_fw_sel = $unsigned($random(seed)) % 3;
        mem_base = $random(seed) & ~32'd3;
        mem_offset = $random(seed) & ~32'd3;
        if (mem_kind == 2) mem_offset = mem_offset | (32'd1 + $unsigned($random(seed)) % 3);
        mem_wdata = $random(seed);
        mem_dst = $random(seed);
        base = mem_fw_valid ? fwd_value(mem_fw_sel) : mem_base;
        addr = base + mem_offset;
        misal = addr[1:0] != 2'b00;
        mdata = mem_is_load ? (misal ? 32'd0 : mem_word(addr)) : mem_wdata;
        if (!misal && mem_is_load) q_rd_addr.push_back(addr);
        if (!misal && !mem_is_load) begin
            q_wr_addr.push_back(addr);
            q_wr_data.push_back(mem_wdata);
        end
        q_alu.push_back(res);
        q_of.push_back(of);
        q_mem.push_back(mdata);
        q_addr.push_back(addr);
        q_exc.push_back({misal & ~mem_is_load, misal & mem_is_load});
        q_rob.push_back({mem_dst, alu_dst});
        prev_alu = res;
        prev_mem = mdata;
        have_prev = 1'b1;
        sent++;
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    // memory answers a read after 0 to 3 cycles and the ROB frees beats unless held back
    always @(negedge clk) begin
        d_data_ok = 1'b0;
        rd = '0;
        commit_credit = 1'b0;
        if (mread_valid && delay == 0) begin
            d_data_ok = 1'b1;
            rd = mem_word(mread_addr);
            delay = $unsigned($random(seed)) % 4;
        end else if (mread_valid) begin
            delay--;
        end
        if (!withhold && owed > 0) begin
            commit_credit = 1'b1;
            owed--;
        end
    end

    always @(posedge clk) begin
        if (issue_credit) begin
            have_credit = 1'b1;
            credits_back++;
        end
        if (mread_valid && d_data_ok && issue_credit) begin
            if (q_rd_addr.size() == 0) die("memory read issued without an aligned load");
            check("mread addr", q_rd_addr.pop_front(), mread_addr);
        end
        if (mwrite_valid) begin
            if (q_wr_addr.size() == 0) die("memory write issued without an aligned store");
            check("mwrite addr", q_wr_addr.pop_front(), mwrite_addr);
            check("mwrite data", q_wr_data.pop_front(), mwrite_data);
        end
        if (commit_valid) begin
            beats++;
            owed++;
            if (q_alu.size() == 0) die("commit beat without an outstanding group");
            check("lane valids", {(N+1){1'b1}}, {agu_commit_valid, alu_commit_valid});
            check("alu data", q_alu.pop_front(), alu_commit_data);
            check("alu overflow", q_of.pop_front(), alu_commit_of);
            check("agu data", q_mem.pop_front(), agu_commit_data);
            check("agu addr", q_addr.pop_front(), agu_commit_addr);
            check("exceptions", q_exc.pop_front(), {agu_commit_exc_save, agu_commit_exc_load});
            check("rob tags", q_rob.pop_front(), {agu_commit_rob, alu_commit_rob});
        end
    end

    initial begin
        repeat (200 * TOTAL_GROUPS) @(posedge clk);
        die("watchdog timeout, the stage stopped committing groups");
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        {issue_valid, mem_valid, mem_is_load, mem_fw_valid, d_data_ok, commit_credit} = '0;
        {alu_valid, alu_fw1_valid, alu_fw2_valid, alu_func, alu_src1, alu_src2} = '0;
        {alu_dst, alu_fw1_sel, alu_fw2_sel, mem_fw_sel, mem_base, mem_offset} = '0;
        {mem_wdata, mem_dst, rd} = '0;
        {have_credit, withhold, have_prev} = 3'b100;
        {sent, credits_back, beats, owed, delay} = '0;
        repeat (3) @(posedge clk);
        @(negedge clk) rst_n = 1'b1;
        alu_valid = '1;
        mem_valid = 1'b1;
        test_name = "idle";
        repeat (4) @(negedge clk) check("valids", 0, {commit_valid, alu_commit_valid,
                                                      agu_commit_valid, mread_valid,
                                                      mwrite_valid, issue_credit});
        test_name = "alu";
        for (int i = 0; i < 40; i++) send_group(i % 2, 0, 1);
        test_name = "forward";
        repeat (40) send_group(0, 1, 0);
        test_name = "load";
        repeat (20) send_group(0, 0, 0);
        test_name = "store";
        repeat (20) send_group(0, 0, 1);
        test_name = "misaligned";
        repeat (20) send_group(0, 1, 2);
        test_name = "credits";
        while (q_alu.size() != 0 || owed != 0) @(negedge clk);
        @(negedge clk);
        withhold = 1'b1;
        beats = 0;
        fork
            repeat (6) send_group(0, 0, coin());
            begin
                while (beats < `COMMIT_CREDITS) @(negedge clk);
                repeat (20) @(negedge clk);
                check("beats before stall", `COMMIT_CREDITS, beats);
                withhold = 1'b0;
            end
        join
        while (q_alu.size() != 0) @(negedge clk);
        check("issue credits", sent, credits_back);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+common
common/exec_pkg.sv
execute/operand_forward.sv
execute/alu.sv
execute/agu.sv
execute/execute.sv
design/issue_reg.sv
design/execute_top.sv
tests/execute_top_assert.sv
tests/execute_top_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module execute_top_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/Vexecute_top_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit $status
fi
exit 0
